// ==== filelist.f ====
hw/cnn_pkg.sv
hw/inst_decoder.sv
hw/window_buffer.sv
hw/mac_array.sv
hw/result_scaler.sv
hw/cnn_top.sv
sim/tb_cnn_top.sv

// ==== sim/tb_cnn_top.sv ====
module tb_cnn_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int MARGIN_CYCLES = 120;   // Reset, quiet time and pipeline tail

	logic            clk = 1'b0;
	logic            arst_n;
	cnn_pkg::inst_t  instruct;
	logic            inst_empty;
	logic            inst_req;
	cnn_pkg::beat_t  fifo_data;
	logic            fifo_empty;
	logic            fifo_req;
	cnn_pkg::pixel_t result;
	logic            result_valid;

	// Queue models and scoreboard
	cnn_pkg::inst_t  inst_q [$];
	cnn_pkg::beat_t  op_q [$];
	int              gap_q [$];        // Empty cycles shown before each beat
	logic            flag_q [$];       // Beat completes a window
	cnn_pkg::pixel_t exp_q [$];
	int              tid_q [$];
	cnn_pkg::beat_t  kern [3];
	logic [31:0]     lfsr;
	logic            go;
	logic            built;
	logic            head_completes;
	logic            win_accept;
	int              rd_idx;
	int              n_exp;
	int              n_work;
	cnn_pkg::pixel_t exp_val;
	int              exp_tid;
	string           test_names [5] =
		'{"limits", "nop", "random_lines", "reload", "back_to_back"};

	always #(CLK_PERIOD / 2) clk = ~clk;

	cnn_top i_dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.instruct     (instruct),
		.inst_empty   (inst_empty),
		.inst_req     (inst_req),
		.fifo_data    (fifo_data),
		.fifo_empty   (fifo_empty),
		.fifo_req     (fifo_req),
		.result       (result),
		.result_valid (result_valid)
	);

	////////////////////
	// Stimulus helpers
	////////////////////
	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic cnn_pkg::pixel_t gen_value(bit extreme);
		if (extreme)
			return (take_bits(1) != 0) ? 8'sd127 : -8'sd128;   // Drives sums to the rails
		return cnn_pkg::pixel_t'(take_bits(8));
	endfunction

	function automatic int byte_at(cnn_pkg::beat_t v, int r);
		cnn_pkg::pixel_t b;
		b = v[8*r +: 8];
		return b;
	endfunction

	// Window sum with optional bias, floor shift, clamp to 8 bits
	function automatic cnn_pkg::pixel_t expected_pixel(cnn_pkg::beat_t c0, cnn_pkg::beat_t c1,
			cnn_pkg::beat_t c2, logic ub, cnn_pkg::bias_t b, cnn_pkg::shift_t sh);
		cnn_pkg::beat_t cols [3];
		int acc;
		cols = '{c0, c1, c2};
		acc = ub ? int'(b) : 0;
		for (int c = 0; c < 3; c++)
			for (int r = 0; r < 3; r++)
				acc += byte_at(cols[c], r) * byte_at(kern[c], r);
		acc = acc >>> sh;
		if (acc > 127)
			return 8'sd127;
		else if (acc < -128)
			return -8'sd128;
		return cnn_pkg::pixel_t'(acc);
	endfunction

	task automatic push_beat(cnn_pkg::beat_t b, logic completes, bit gapped);
		op_q.push_back(b);
		flag_q.push_back(completes);
		if (gapped && take_bits(1) != 0)
			gap_q.push_back(int'(take_bits(2)));
		else
			gap_q.push_back(0);
	endtask

	task automatic add_load(bit gapped, bit extreme);
		cnn_pkg::inst_t inst;
		cnn_pkg::beat_t b;
		inst = '0;
		inst[cnn_pkg::OPC_MSB:cnn_pkg::OPC_LSB] = cnn_pkg::OP_LOAD_WEIGHTS;
		inst_q.push_back(inst);
		for (int c = 0; c < cnn_pkg::KERNEL_COLS; c++) begin
			b = {gen_value(extreme), gen_value(extreme), gen_value(extreme)};
			kern[c] = b;   // First beat is kernel column 0
			push_beat(b, 1'b0, gapped);
		end
	endtask

	task automatic add_conv(int tid, int n, bit gapped, bit extreme);
		cnn_pkg::inst_t  inst;
		cnn_pkg::beat_t  b;
		cnn_pkg::beat_t  cols [$];
		logic            ub;
		cnn_pkg::bias_t  bias;
		cnn_pkg::shift_t sh;
		ub = 1'(take_bits(1));
		bias = cnn_pkg::bias_t'(take_bits(16));
		sh = extreme ? cnn_pkg::shift_t'(take_bits(2)) : cnn_pkg::shift_t'(take_bits(4));
		inst = '0;
		inst[cnn_pkg::OPC_MSB:cnn_pkg::OPC_LSB] = cnn_pkg::OP_CONV_LINE;
		inst[cnn_pkg::USE_BIAS_BIT] = ub;
		inst[cnn_pkg::SHIFT_MSB:cnn_pkg::SHIFT_LSB] = sh;
		inst[cnn_pkg::BIAS_MSB:cnn_pkg::BIAS_LSB] = bias;
		inst[cnn_pkg::COUNT_MSB:cnn_pkg::COUNT_LSB] = cnn_pkg::count_t'(n);
		inst_q.push_back(inst);
		for (int k = 0; k < n; k++) begin
			b = {gen_value(extreme), gen_value(extreme), gen_value(extreme)};
			cols.push_back(b);
			push_beat(b, k >= 2, gapped);
			if (k >= 2) begin
				exp_q.push_back(expected_pixel(cols[k-2], cols[k-1], cols[k], ub, bias, sh));
				tid_q.push_back(tid);
			end
		end
	endtask

	task automatic build_tests();
		cnn_pkg::inst_t nop;
		nop = '0;
		nop[cnn_pkg::OPC_MSB:cnn_pkg::OPC_LSB] = cnn_pkg::OP_NOP;
		add_load(1'b0, 1'b1);
		add_conv(0, 6, 1'b0, 1'b1);
		add_conv(0, 5, 1'b0, 1'b1);
		inst_q.push_back(nop);   // Dropped by the decoder
		add_conv(1, 3, 1'b0, 1'b0);
		add_load(1'b1, 1'b0);
		for (int i = 0; i < 4; i++)
			add_conv(2, 3 + int'(take_bits(3)), 1'b1, 1'b0);
		add_load(1'b1, 1'b0);
		add_conv(3, 5, 1'b1, 1'b0);
		add_load(1'b1, 1'b0);
		add_conv(3, 5, 1'b1, 1'b0);
		for (int i = 0; i < 3; i++)
			add_conv(4, 3 + int'(take_bits(2)), 1'b0, 1'b0);
	endtask

	////////////////////
	// Queue drivers
	////////////////////
	always @(negedge clk) begin
		inst_empty = !go || (inst_q.size() == 0);
		if (inst_q.size() > 0)
			instruct = inst_q[0];
		if (go && gap_q.size() > 0 && gap_q[0] > 0) begin
			gap_q[0] = gap_q[0] - 1;
			fifo_empty = 1'b1;
		end else begin
			fifo_empty = !go || (op_q.size() == 0);
		end
		if (op_q.size() > 0) begin
			fifo_data = op_q[0];
			head_completes = flag_q[0];
		end else begin
			head_completes = 1'b0;
		end
	end

	// Words leave the queues on the consuming edge
	always @(posedge clk) begin
		if (inst_req)
			void'(inst_q.pop_front());
		if (fifo_req) begin
			void'(op_q.pop_front());
			void'(gap_q.pop_front());
			void'(flag_q.pop_front());
		end
		if (arst_n && result_valid && rd_idx < n_exp) begin
			if (rd_idx + 1 < n_exp) begin
				exp_val <= exp_q[rd_idx + 1];
				exp_tid <= tid_q[rd_idx + 1];
			end
			rd_idx <= rd_idx + 1;
		end
	end

	assign win_accept = fifo_req && head_completes;

	////////////////////
	// Checks
	////////////////////
	a_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		!go |-> (!inst_req && !fifo_req && !result_valid))
	else begin
		$display("Outputs became active before any queue held data");
		abort_run();
	end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
		!(inst_req && inst_empty) && !(fifo_req && fifo_empty))
	else begin
		$display("A request was raised while its queue was empty");
		abort_run();
	end

	a_no_extra: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid |-> (rd_idx < n_exp))
	else begin
		$display("A result arrived with nothing left in the scoreboard");
		abort_run();
	end

	a_result_value: assert property (@(posedge clk) disable iff (!arst_n)
		(result_valid && rd_idx < n_exp) |-> (result == exp_val))
	else begin
		$display("Fail %s: expected %0d, actual %0d", test_names[$sampled(exp_tid)],
			$sampled(exp_val), $sampled(result));
		abort_run();
	end

	// Set PIPE_LATENCY edges after the accepting edge and seen at the next sample
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid == $past(win_accept, cnn_pkg::PIPE_LATENCY + 1))
	else begin
		$display("Fail pipe_latency: expected result_valid %0b, actual %0b",
			!$sampled(result_valid), $sampled(result_valid));
		abort_run();
	end

	initial begin
		wait (built === 1'b1);
		#((n_work * 4 + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: queues or scoreboard did not drain in time");
		abort_run();
	end

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		arst_n = 1'b0;
		go = 1'b0;
		built = 1'b0;
		instruct = '0;
		inst_empty = 1'b1;
		fifo_data = '0;
		fifo_empty = 1'b1;
		head_completes = 1'b0;
		rd_idx = 0;
		lfsr = 32'h9473_0c6f;
		build_tests();
		n_exp = exp_q.size();
		exp_val = exp_q[0];
		exp_tid = tid_q[0];
		n_work = op_q.size() + inst_q.size();
		built = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		repeat (6) @(negedge clk);   // Idle with empty queues
		go = 1'b1;
		while (rd_idx < n_exp || inst_q.size() > 0 || op_q.size() > 0)
			@(negedge clk);
		repeat (2 * cnn_pkg::PIPE_LATENCY) @(negedge clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== hw/cnn_top.sv ====
module cnn_top (
	input  logic            clk,
	input  logic            arst_n,
	input  cnn_pkg::inst_t  instruct,
	input  logic            inst_empty,
	output logic            inst_req,
	input  cnn_pkg::beat_t  fifo_data,
	input  logic            fifo_empty,
	output logic            fifo_req,
	output cnn_pkg::pixel_t result,
	output logic            result_valid
);

	// Decoder to window
	cnn_pkg::beat_t            beat;
	logic                      weight_we;
	logic                      column_we;
	logic                      line_start;
	logic                      use_bias;
	cnn_pkg::bias_t            bias;
	cnn_pkg::shift_t           shift;

	// Window to MAC
	cnn_pkg::pixel_t  [8:0]    win_pixels;
	cnn_pkg::weight_t [8:0]    win_weights;
	logic                      win_valid;
	logic                      win_use_bias;
	cnn_pkg::bias_t            win_bias;
	cnn_pkg::shift_t           win_shift;

	// MAC to output
	cnn_pkg::acc_t             sum;
	logic                      sum_valid;
	cnn_pkg::shift_t           sum_shift;

	////////////////////
	// Input side
	////////////////////
	inst_decoder i_decoder (
		.clk        (clk),
		.arst_n     (arst_n),
		.instruct   (instruct),
		.inst_empty (inst_empty),
		.fifo_data  (fifo_data),
		.fifo_empty (fifo_empty),
		.inst_req   (inst_req),
		.fifo_req   (fifo_req),
		.beat       (beat),
		.weight_we  (weight_we),
		.column_we  (column_we),
		.line_start (line_start),
		.use_bias   (use_bias),
		.bias       (bias),
		.shift      (shift)
	);

	////////////////////
	// Processing
	////////////////////
	window_buffer i_window (
		.clk          (clk),
		.arst_n       (arst_n),
		.beat         (beat),
		.weight_we    (weight_we),
		.column_we    (column_we),
		.line_start   (line_start),
		.use_bias     (use_bias),
		.bias         (bias),
		.shift        (shift),
		.win_pixels   (win_pixels),
		.win_weights  (win_weights),
		.win_valid    (win_valid),
		.win_use_bias (win_use_bias),
		.win_bias     (win_bias),
		.win_shift    (win_shift)
	);

	mac_array i_mac (
		.clk          (clk),
		.arst_n       (arst_n),
		.win_pixels   (win_pixels),
		.win_weights  (win_weights),
		.win_valid    (win_valid),
		.win_use_bias (win_use_bias),
		.win_bias     (win_bias),
		.win_shift    (win_shift),
		.sum          (sum),
		.sum_valid    (sum_valid),
		.sum_shift    (sum_shift)
	);

	////////////////////
	// Output side
	////////////////////
	result_scaler i_scaler (
		.clk          (clk),
		.arst_n       (arst_n),
		.sum          (sum),
		.sum_valid    (sum_valid),
		.sum_shift    (sum_shift),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

// ==== hw/result_scaler.sv ====
module result_scaler (
	input  logic            clk,
	input  logic            arst_n,
	input  cnn_pkg::acc_t   sum,
	input  logic            sum_valid,
	input  cnn_pkg::shift_t sum_shift,
	output cnn_pkg::pixel_t result,
	output logic            result_valid
);

	cnn_pkg::acc_t   shifted;
	cnn_pkg::pixel_t clamped;

	// Arithmetic shift floors toward minus infinity
	assign shifted = sum >>> sum_shift;

	always_comb begin
		if (shifted > cnn_pkg::acc_t'(127))
			clamped = 8'sd127;
		else if (shifted < -cnn_pkg::acc_t'(128))
			clamped = -8'sd128;
		else
			clamped = shifted[cnn_pkg::PIXEL_W-1:0];
	end

	always_ff @(posedge clk) begin
		result <= clamped;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			result_valid <= 1'b0;
		else
			result_valid <= sum_valid;
	end

	////////////////////
	// Back-to-back results need back-to-back sums
	////////////////////
	a_burst_source: assert property (
		@(posedge clk) disable iff (!arst_n)
		(result_valid && $past(result_valid)) |-> ($past(sum_valid) && $past(sum_valid, 2))
	);

endmodule

// ==== hw/mac_array.sv ====
module mac_array (
	input  logic                       clk,
	input  logic                       arst_n,
	input  cnn_pkg::pixel_t  [8:0]     win_pixels,
	input  cnn_pkg::weight_t [8:0]     win_weights,
	input  logic                       win_valid,
	input  logic                       win_use_bias,
	input  cnn_pkg::bias_t             win_bias,
	input  cnn_pkg::shift_t            win_shift,
	output cnn_pkg::acc_t              sum,
	output logic                       sum_valid,
	output cnn_pkg::shift_t            sum_shift
);

	cnn_pkg::prod_t  prod [cnn_pkg::KERNEL_TAPS];
	logic            prod_valid;
	logic            prod_use_bias;
	cnn_pkg::bias_t  prod_bias;
	cnn_pkg::shift_t prod_shift;

	cnn_pkg::acc_t   tree_sum;

	////////////////////
	// Stage 1 products
	////////////////////
	always_ff @(posedge clk) begin
		for (int i = 0; i < cnn_pkg::KERNEL_TAPS; i++) begin
			// Same column and row on both sides
			prod[i] <= $signed(win_pixels[i]) * $signed(win_weights[i]);
		end
		prod_use_bias <= win_use_bias;
		prod_bias     <= win_bias;
		prod_shift    <= win_shift;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			prod_valid <= 1'b0;
		else
			prod_valid <= win_valid;
	end

	////////////////////
	// Stage 2 sum and bias
	////////////////////
	always_comb begin
		tree_sum = prod_use_bias ? cnn_pkg::acc_t'(prod_bias) : '0;
		for (int i = 0; i < cnn_pkg::KERNEL_TAPS; i++)
			tree_sum = tree_sum + prod[i];   // Sign extended to 24 bits
	end

	always_ff @(posedge clk) begin
		sum       <= tree_sum;
		sum_shift <= prod_shift;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			sum_valid <= 1'b0;
		else
			sum_valid <= prod_valid;
	end

endmodule

// ==== hw/window_buffer.sv ====
module window_buffer (
	input  logic                       clk,
	input  logic                       arst_n,
	input  cnn_pkg::beat_t             beat,
	input  logic                       weight_we,
	input  logic                       column_we,
	input  logic                       line_start,
	input  logic                       use_bias,
	input  cnn_pkg::bias_t             bias,
	input  cnn_pkg::shift_t            shift,
	output cnn_pkg::pixel_t  [8:0]     win_pixels,
	output cnn_pkg::weight_t [8:0]     win_weights,
	output logic                       win_valid,
	output logic                       win_use_bias,
	output cnn_pkg::bias_t             win_bias,
	output cnn_pkg::shift_t            win_shift
);

	// Index 0 is the oldest column, index 2 the newest
	cnn_pkg::beat_t [2:0] kernel_cols;
	cnn_pkg::beat_t [2:0] feature_cols;
	logic           [1:0] fill;        // Columns of the current line held, saturates at 2
	logic                 complete;

	// Element 3*col+row lines up with byte row of beat col
	assign win_weights = kernel_cols;
	assign win_pixels  = feature_cols;

	// Third or later column of the same line
	assign complete = column_we && !line_start && (fill == 2'd2);

	////////////////////
	// Kernel store
	////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			kernel_cols <= '0;
		else if (weight_we)
			kernel_cols <= {beat, kernel_cols[2:1]};
	end

	// Feature window
	always_ff @(posedge clk) begin
		if (column_we)
			feature_cols <= {beat, feature_cols[2:1]};
	end

	////////////////////
	// Fill tracking and window strobe
	////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fill      <= 2'd0;
			win_valid <= 1'b0;
		end else begin
			win_valid <= complete;
			if (column_we) begin
				if (line_start)
					fill <= 2'd1;   // Restart, no window crosses lines
				else if (fill != 2'd2)
					fill <= fill + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (complete) begin
			win_use_bias <= use_bias;
			win_bias     <= bias;
			win_shift    <= shift;
		end
	end

	// Decoder serves one operation at a time
	a_one_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(weight_we && column_we)
	);

endmodule

// ==== hw/inst_decoder.sv ====
module inst_decoder (
	input  logic            clk,
	input  logic            arst_n,
	input  cnn_pkg::inst_t  instruct,
	input  logic            inst_empty,
	input  cnn_pkg::beat_t  fifo_data,
	input  logic            fifo_empty,
	output logic            inst_req,
	output logic            fifo_req,
	output cnn_pkg::beat_t  beat,
	output logic            weight_we,
	output logic            column_we,
	output logic            line_start,
	output logic            use_bias,
	output cnn_pkg::bias_t  bias,
	output cnn_pkg::shift_t shift
);

	cnn_pkg::dec_state_t state;
	cnn_pkg::count_t     remaining;   // Beats still owed by this instruction
	logic                first_col;

	cnn_pkg::opcode_t    opcode;
	cnn_pkg::count_t     inst_count;
	logic                take_conv;

	////////////////////
	// Field extraction
	////////////////////
	assign opcode     = cnn_pkg::opcode_t'(instruct[cnn_pkg::OPC_MSB:cnn_pkg::OPC_LSB]);
	assign inst_count = instruct[cnn_pkg::COUNT_MSB:cnn_pkg::COUNT_LSB];
	assign take_conv  = inst_req && (opcode == cnn_pkg::OP_CONV_LINE);

	// Fetch only when idle, pop operands only when busy
	always_comb begin
		inst_req = (state == cnn_pkg::S_IDLE) && !inst_empty;
		fifo_req = (state != cnn_pkg::S_IDLE) && !fifo_empty;
	end

	////////////////////
	// Control FSM
	////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= cnn_pkg::S_IDLE;
			remaining  <= '0;
			first_col  <= 1'b0;
			weight_we  <= 1'b0;
			column_we  <= 1'b0;
			line_start <= 1'b0;
		end else begin
			// Strobes travel one cycle behind the accepted beat
			weight_we  <= fifo_req && (state == cnn_pkg::S_LOAD);
			column_we  <= fifo_req && (state == cnn_pkg::S_CONV);
			line_start <= fifo_req && (state == cnn_pkg::S_CONV) && first_col;

			case (state)
				cnn_pkg::S_IDLE: begin
					if (inst_req) begin
						case (opcode)
							cnn_pkg::OP_LOAD_WEIGHTS: begin
								state     <= cnn_pkg::S_LOAD;
								remaining <= cnn_pkg::count_t'(cnn_pkg::KERNEL_COLS);
							end
							cnn_pkg::OP_CONV_LINE: begin
								state     <= cnn_pkg::S_CONV;
								remaining <= inst_count;
								first_col <= 1'b1;
							end
							cnn_pkg::OP_NOP: ;   // Dropped
							default: ;
						endcase
					end
				end
				default: begin
					if (fifo_req) begin
						first_col <= 1'b0;
						remaining <= remaining - 1'b1;
						if (remaining == cnn_pkg::count_t'(1))
							state <= cnn_pkg::S_IDLE;   // Do not wait for the pipe
					end
				end
			endcase
		end
	end

	////////////////////
	// Payload registers
	////////////////////
	always_ff @(posedge clk) begin
		if (fifo_req)
			beat <= fifo_data;
		// Side band is only taken from conv instructions so it stays with its line
		if (take_conv) begin
			use_bias <= instruct[cnn_pkg::USE_BIAS_BIT];
			bias     <= instruct[cnn_pkg::BIAS_MSB:cnn_pkg::BIAS_LSB];
			shift    <= instruct[cnn_pkg::SHIFT_MSB:cnn_pkg::SHIFT_LSB];
		end
	end

	////////////////////
	// Checks
	////////////////////
	// Operand queue is never popped while empty
	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!arst_n)
		fifo_req |-> !fifo_empty
	);

	// A line shorter than the kernel cannot yield a window
	a_conv_count: assert property (
		@(posedge clk) disable iff (!arst_n)
		take_conv |-> (inst_count >= cnn_pkg::count_t'(cnn_pkg::KERNEL_COLS))
	);

endmodule

// ==== hw/cnn_pkg.sv ====
package cnn_pkg;

	////////////////////
	// Widths
	////////////////////
	localparam int PIXEL_W      = 8;
	localparam int BEAT_W       = 3 * PIXEL_W;   // Three rows per beat
	localparam int PROD_W       = 2 * PIXEL_W;
	localparam int ACC_W        = 24;            // Same as COM_DATALEN
	localparam int BIAS_W       = 16;
	localparam int SHIFT_W      = 5;
	localparam int COUNT_W      = 9;             // Same as MAX_LINE_LEN
	localparam int INST_LEN     = 48;

	localparam int KERNEL_COLS  = 3;
	localparam int KERNEL_TAPS  = 9;
	localparam int PIPE_LATENCY = 4;             // Accepting edge to result_valid

	////////////////////
	// Instruction layout, packed from the top bit down
	////////////////////
	localparam int OPC_MSB      = INST_LEN - 1;
	localparam int OPC_LSB      = INST_LEN - 2;
	localparam int USE_BIAS_BIT = OPC_LSB - 1;
	localparam int SHIFT_MSB    = USE_BIAS_BIT - 1;
	localparam int SHIFT_LSB    = SHIFT_MSB - SHIFT_W + 1;
	localparam int BIAS_MSB     = SHIFT_LSB - 1;
	localparam int BIAS_LSB     = BIAS_MSB - BIAS_W + 1;
	localparam int COUNT_MSB    = BIAS_LSB - 1;
	localparam int COUNT_LSB    = COUNT_MSB - COUNT_W + 1;  // Bits below are zero

	typedef logic signed [PIXEL_W-1:0] pixel_t;
	typedef logic signed [PIXEL_W-1:0] weight_t;
	typedef logic        [BEAT_W-1:0]  beat_t;   // Row 0 in the low byte
	typedef logic signed [PROD_W-1:0]  prod_t;
	typedef logic signed [ACC_W-1:0]   acc_t;
	typedef logic signed [BIAS_W-1:0]  bias_t;
	typedef logic        [SHIFT_W-1:0] shift_t;
	typedef logic        [COUNT_W-1:0] count_t;
	typedef logic        [INST_LEN-1:0] inst_t;

	typedef enum logic [1:0] {
		OP_LOAD_WEIGHTS = 2'd0,
		OP_CONV_LINE    = 2'd1,
		OP_NOP          = 2'd2
	} opcode_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOAD,
		S_CONV
	} dec_state_t;

endpackage
